//--- hw/oq_pkg.sv
// Shared sizing for the output-queue subsystem
// Widths here are defaults; the top level passes its own values down
// Buffer sizing assumes the data width is a power-of-two number of bytes

package oq_pkg;

   // Default stream widths, one word each
   localparam int DATA_WIDTH = 64;
   localparam int USER_WIDTH = 128;

   localparam int NUM_QUEUES = 3;

   // Queue q is selected by tuser[DST_POS + 2*q]
   localparam int DST_POS = 24;

   // Per-queue data buffer and largest packet, in bytes
   localparam int BUFFER_BYTES  = 4096;
   localparam int MAX_PKT_BYTES = 1600;

   // Metadata FIFO holds four packet headers
   localparam int META_DEPTH_BITS = 2;

   // log2 of buffer depth in words
   function automatic int data_depth_bits(input int data_width);
      return $clog2(BUFFER_BYTES / (data_width / 8));
   endfunction

   // Fill level in words above which a maximum packet no longer fits
   function automatic int admit_threshold(input int data_width);
      int word_bytes;
      word_bytes = data_width / 8;
      return (BUFFER_BYTES - MAX_PKT_BYTES) / word_bytes;
   endfunction

endpackage

//--- hw/oq_stream_if.sv
// AXI4-Stream bundle with tuser, used between blocks inside the queue subsystem
// tstrb is one bit per data byte

`timescale 1ns/100ps

interface oq_stream_if #(
   parameter int DATA_WIDTH = oq_pkg::DATA_WIDTH,
   parameter int USER_WIDTH = oq_pkg::USER_WIDTH
);

   logic [DATA_WIDTH-1:0]   tdata;
   logic [DATA_WIDTH/8-1:0] tstrb;
   logic [USER_WIDTH-1:0]   tuser;
   logic                    tlast;
   logic                    tvalid;
   logic                    tready;

   // Producer side
   modport source (
      output tdata, tstrb, tuser, tlast, tvalid,
      input  tready
   );

   // Consumer side
   modport sink (
      input  tdata, tstrb, tuser, tlast, tvalid,
      output tready
   );

endinterface

//--- hw/oq_fallthrough_fifo.sv
// Synchronous first-word-fall-through FIFO, head is read combinationally
// Writes while full and reads while empty are ignored
// Depth is 2**DEPTH_BITS entries

`timescale 1ns/100ps

module oq_fallthrough_fifo #(
   parameter type payload_t       = logic [7:0],
   parameter int  DEPTH_BITS      = 4,
   parameter int  PROG_FULL_LEVEL = (1 << DEPTH_BITS) - 2
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   input  payload_t din,
   input  logic     wr_en,
   input  logic     rd_en,
   output payload_t dout,
   output logic     empty,
   output logic     nearly_full,
   output logic     prog_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   // Fill levels at the width of the counter
   localparam logic [DEPTH_BITS:0] FULL_COUNT   = (DEPTH_BITS + 1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] NEARLY_COUNT = (DEPTH_BITS + 1)'(DEPTH - 1);
   localparam logic [DEPTH_BITS:0] PROG_COUNT   = (DEPTH_BITS + 1)'(PROG_FULL_LEVEL);

   payload_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_write;
   logic                  do_read;

   assign do_write = wr_en && (count != FULL_COUNT);
   assign do_read  = rd_en && !empty;

   // Storage
   always_ff @(posedge axi_aclk) begin
      if (do_write) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers and fill count
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= NEARLY_COUNT);   // one slot or less left
   assign prog_full   = (count > PROG_COUNT);

endmodule

//--- hw/oq_input_steer.sv
// Input FSM: decides per packet whether to write it to its queues or drop it
// Decision uses the first word's tuser and the registered admit_block flags
// Output back-pressure never stalls the input; blocked packets are dropped

`timescale 1ns/100ps

module oq_input_steer #(
   parameter int NUM_QUEUES = oq_pkg::NUM_QUEUES,
   parameter int USER_WIDTH = oq_pkg::USER_WIDTH
) (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   oq_stream_if.sink             in,
   input  logic [NUM_QUEUES-1:0] admit_block,
   output logic [NUM_QUEUES-1:0] wr_data,
   output logic [NUM_QUEUES-1:0] wr_meta
);

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      DROP
   } state_t;

   state_t                state;
   state_t                state_next;
   logic [USER_WIDTH-1:0] head_user;
   logic [NUM_QUEUES-1:0] dst_set;
   logic [NUM_QUEUES-1:0] cur_queue;
   logic [NUM_QUEUES-1:0] cur_queue_next;
   logic                  first_word;
   logic                  first_word_next;
   logic                  admit;

   //////////////////////////////////////////////////////////////////////////
   // Destination decode, even bits of the destination field only

   assign head_user = in.tuser;

   always_comb begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
         dst_set[q] = head_user[oq_pkg::DST_POS + 2 * q];
      end
   end

   // All selected queues must have room, and at least one must be selected
   assign admit = (|dst_set) && !(|(dst_set & admit_block));

   //////////////////////////////////////////////////////////////////////////
   // Packet FSM

   always_comb begin
      state_next      = state;
      cur_queue_next  = cur_queue;
      first_word_next = first_word;
      wr_data         = '0;
      wr_meta         = '0;
      case (state)
         IDLE: begin
            cur_queue_next = dst_set;
            if (in.tvalid) begin
               if (admit) begin
                  state_next      = WRITE;
                  first_word_next = 1'b1;
               end else begin
                  state_next = DROP;
               end
            end
         end
         WRITE: begin
            if (in.tvalid) begin
               first_word_next = 1'b0;
               wr_data         = cur_queue;
               if (first_word) begin
                  wr_meta = cur_queue;   // one metadata entry per packet
               end
               if (in.tlast) begin
                  state_next = IDLE;
               end
            end
         end
         DROP: begin
            if (in.tvalid && in.tlast) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= IDLE;
         cur_queue  <= '0;
         first_word <= 1'b0;
      end else begin
         state      <= state_next;
         cur_queue  <= cur_queue_next;
         first_word <= first_word_next;
      end
   end

   // Words are only taken once the decision is made
   assign in.tready = (state != IDLE);

endmodule

//--- hw/oq_queue_port.sv
// One output queue: data FIFO and metadata FIFO side by side, joined by a reader
// tuser of a packet is held on every word until tlast transfers
// admit_block lags the FIFO fill by one cycle

`timescale 1ns/100ps

module oq_queue_port #(
   parameter int DATA_WIDTH = oq_pkg::DATA_WIDTH,
   parameter int USER_WIDTH = oq_pkg::USER_WIDTH
) (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   input  logic [DATA_WIDTH-1:0]   in_tdata,
   input  logic [DATA_WIDTH/8-1:0] in_tstrb,
   input  logic                    in_tlast,
   input  logic [USER_WIDTH-1:0]   in_tuser,
   input  logic                    wr_data,
   input  logic                    wr_meta,
   output logic                    admit_block,
   oq_stream_if.source             out
);

   typedef struct packed {
      logic                    tlast;
      logic [DATA_WIDTH/8-1:0] tstrb;
      logic [DATA_WIDTH-1:0]   tdata;
   } data_word_t;

   typedef enum logic {
      HEADER,
      EOP
   } rd_state_t;

   data_word_t            data_in;
   data_word_t            data_head;
   logic [USER_WIDTH-1:0] meta_head;
   logic                  data_empty;
   logic                  data_prog_full;
   logic                  meta_empty;
   logic                  meta_nearly_full;
   logic                  data_rd;
   logic                  meta_rd;
   rd_state_t             rd_state;

   assign data_in = '{tlast: in_tlast, tstrb: in_tstrb, tdata: in_tdata};

   oq_fallthrough_fifo #(
      .payload_t       (data_word_t),
      .DEPTH_BITS      (oq_pkg::data_depth_bits(DATA_WIDTH)),
      .PROG_FULL_LEVEL (oq_pkg::admit_threshold(DATA_WIDTH))
   ) data_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (data_in),
      .wr_en       (wr_data),
      .rd_en       (data_rd),
      .dout        (data_head),
      .empty       (data_empty),
      .nearly_full (),
      .prog_full   (data_prog_full)
   );

   oq_fallthrough_fifo #(
      .payload_t       (logic [USER_WIDTH-1:0]),
      .DEPTH_BITS      (oq_pkg::META_DEPTH_BITS),
      .PROG_FULL_LEVEL ((1 << oq_pkg::META_DEPTH_BITS) - 1)
   ) meta_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (in_tuser),
      .wr_en       (wr_meta),
      .rd_en       (meta_rd),
      .dout        (meta_head),
      .empty       (meta_empty),
      .nearly_full (meta_nearly_full),
      .prog_full   ()
   );

   //////////////////////////////////////////////////////////////////////////
   // Reader

   // Header word also needs its metadata entry present
   assign out.tvalid = !data_empty && ((rd_state == EOP) || !meta_empty);
   assign data_rd    = out.tvalid && out.tready;
   assign meta_rd    = data_rd && data_head.tlast;   // pop at end of packet

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_state <= HEADER;
      end else if (data_rd) begin
         rd_state <= data_head.tlast ? HEADER : EOP;
      end
   end

   assign out.tdata = data_head.tdata;
   assign out.tstrb = data_head.tstrb;
   assign out.tlast = data_head.tlast;
   assign out.tuser = meta_head;

   // Room check seen by the input FSM
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         admit_block <= 1'b0;
      end else begin
         admit_block <= data_prog_full || meta_nearly_full;
      end
   end

endmodule

//--- hw/output_queues.sv
// Output-queue subsystem top: one AXI4-Stream input fanned out to NUM_QUEUES outputs
// Output vectors are flattened, slice q belongs to queue q
// Packets that do not fit in every selected queue are dropped whole

`timescale 1ns/100ps

module output_queues #(
   parameter int DATA_WIDTH = oq_pkg::DATA_WIDTH,
   parameter int USER_WIDTH = oq_pkg::USER_WIDTH,
   parameter int NUM_QUEUES = oq_pkg::NUM_QUEUES
) (
   input  logic                               axi_aclk,
   input  logic                               axi_resetn,

   // Input stream
   input  logic [DATA_WIDTH-1:0]              s_axis_tdata,
   input  logic [DATA_WIDTH/8-1:0]            s_axis_tstrb,
   input  logic [USER_WIDTH-1:0]              s_axis_tuser,
   input  logic                               s_axis_tlast,
   input  logic                               s_axis_tvalid,
   output logic                               s_axis_tready,

   // Output streams, one slice per queue
   output logic [NUM_QUEUES*DATA_WIDTH-1:0]   m_axis_tdata,
   output logic [NUM_QUEUES*DATA_WIDTH/8-1:0] m_axis_tstrb,
   output logic [NUM_QUEUES*USER_WIDTH-1:0]   m_axis_tuser,
   output logic [NUM_QUEUES-1:0]              m_axis_tlast,
   output logic [NUM_QUEUES-1:0]              m_axis_tvalid,
   input  logic [NUM_QUEUES-1:0]              m_axis_tready
);

   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   logic [NUM_QUEUES-1:0] wr_data;
   logic [NUM_QUEUES-1:0] wr_meta;
   logic [NUM_QUEUES-1:0] admit_block;

   oq_stream_if #(
      .DATA_WIDTH (DATA_WIDTH),
      .USER_WIDTH (USER_WIDTH)
   ) in_stream ();

   oq_stream_if #(
      .DATA_WIDTH (DATA_WIDTH),
      .USER_WIDTH (USER_WIDTH)
   ) out_stream [NUM_QUEUES] ();

   //////////////////////////////////////////////////////////////////////////
   // Input side

   assign in_stream.tdata  = s_axis_tdata;
   assign in_stream.tstrb  = s_axis_tstrb;
   assign in_stream.tuser  = s_axis_tuser;
   assign in_stream.tlast  = s_axis_tlast;
   assign in_stream.tvalid = s_axis_tvalid;
   assign s_axis_tready    = in_stream.tready;

   oq_input_steer #(
      .NUM_QUEUES (NUM_QUEUES),
      .USER_WIDTH (USER_WIDTH)
   ) steer (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .in          (in_stream.sink),
      .admit_block (admit_block),
      .wr_data     (wr_data),
      .wr_meta     (wr_meta)
   );

   //////////////////////////////////////////////////////////////////////////
   // Queues, each sees the input word fields in parallel

   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      oq_queue_port #(
         .DATA_WIDTH (DATA_WIDTH),
         .USER_WIDTH (USER_WIDTH)
      ) port (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .in_tdata    (in_stream.tdata),
         .in_tstrb    (in_stream.tstrb),
         .in_tlast    (in_stream.tlast),
         .in_tuser    (in_stream.tuser),
         .wr_data     (wr_data[q]),
         .wr_meta     (wr_meta[q]),
         .admit_block (admit_block[q]),
         .out         (out_stream[q].source)
      );

      // Flatten onto the output vectors
      assign m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH] = out_stream[q].tdata;
      assign m_axis_tstrb[q*STRB_WIDTH +: STRB_WIDTH] = out_stream[q].tstrb;
      assign m_axis_tuser[q*USER_WIDTH +: USER_WIDTH] = out_stream[q].tuser;
      assign m_axis_tlast[q]                          = out_stream[q].tlast;
      assign m_axis_tvalid[q]                         = out_stream[q].tvalid;
      assign out_stream[q].tready                     = m_axis_tready[q];
   end

endmodule

//--- tests/output_queues_assert.sv
// Protocol checks bound into output_queues with stability checked per output queue
// fail_count counts failed checks over the whole run

`timescale 1ns/100ps

module output_queues_assert #(
   parameter int DATA_WIDTH = 64,
   parameter int USER_WIDTH = 128,
   parameter int NUM_QUEUES = 3
) (
   input logic                               axi_aclk,
   input logic                               axi_resetn,
   input logic                               s_axis_tlast,
   input logic                               s_axis_tvalid,
   input logic                               s_axis_tready,
   input logic [NUM_QUEUES*DATA_WIDTH-1:0]   m_axis_tdata,
   input logic [NUM_QUEUES*DATA_WIDTH/8-1:0] m_axis_tstrb,
   input logic [NUM_QUEUES*USER_WIDTH-1:0]   m_axis_tuser,
   input logic [NUM_QUEUES-1:0]              m_axis_tlast,
   input logic [NUM_QUEUES-1:0]              m_axis_tvalid,
   input logic [NUM_QUEUES-1:0]              m_axis_tready
);

   localparam int SW = DATA_WIDTH / 8;

   int fail_count = 0;

   // Everything idle in the cycle after a reset edge
   reset_idle: assert property (@(posedge axi_aclk)
      !axi_resetn |=> (m_axis_tvalid == '0) && !s_axis_tready)
      else begin
         $error("Output valid or input ready right after reset");
         fail_count++;
      end

   // Input FSM back in IDLE after tlast, so no word is taken
   idle_after_last: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      s_axis_tvalid && s_axis_tready && s_axis_tlast |=> !s_axis_tready)
      else begin
         $error("Input ready high in the cycle after tlast");
         fail_count++;
      end

   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      // Stalled word and its metadata held until taken
      hold_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         m_axis_tvalid[q] && !m_axis_tready[q] |=> m_axis_tvalid[q]
            && $stable(m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH])
            && $stable(m_axis_tstrb[q*SW +: SW])
            && $stable(m_axis_tuser[q*USER_WIDTH +: USER_WIDTH])
            && $stable(m_axis_tlast[q]))
         else begin
            $error("Output fields of queue %0d changed under back-pressure", q);
            fail_count++;
         end
   end

endmodule

bind output_queues output_queues_assert #(
   .DATA_WIDTH (DATA_WIDTH),
   .USER_WIDTH (USER_WIDTH),
   .NUM_QUEUES (NUM_QUEUES)
) protocol_checks (.*);

//--- tests/tb_output_queues.sv
// Testbench for output_queues with three queues, 64-bit data and 128-bit tuser
// Admission is predicted only at quiet points where every output is held off

`timescale 1ns/100ps

module tb_output_queues;

   localparam int DW          = 64;
   localparam int UW          = 128;
   localparam int NQ          = 3;
   localparam int DST_POS     = 24;
   // Buffer words of a 4096-byte buffer minus the words of a 1600-byte packet
   localparam int ADMIT_LEVEL = 4096 / 8 - 1600 / 8;
   // Four-entry metadata FIFO blocks with one slot left
   localparam int META_LIMIT  = 3;
   localparam int MODEL_DEPTH = 1024;
   localparam int SEED        = 88518;

   logic               axi_aclk;
   logic               axi_resetn;
   logic [DW-1:0]      s_axis_tdata;
   logic [DW/8-1:0]    s_axis_tstrb;
   logic [UW-1:0]      s_axis_tuser;
   logic               s_axis_tlast;
   logic               s_axis_tvalid;
   logic               s_axis_tready;
   logic [NQ*DW-1:0]   m_axis_tdata;
   logic [NQ*DW/8-1:0] m_axis_tstrb;
   logic [NQ*UW-1:0]   m_axis_tuser;
   logic [NQ-1:0]      m_axis_tlast;
   logic [NQ-1:0]      m_axis_tvalid;
   logic [NQ-1:0]      m_axis_tready;

   // Reference queues with one ring per output
   logic [DW-1:0]   exp_data [NQ][MODEL_DEPTH];
   logic [DW/8-1:0] exp_strb [NQ][MODEL_DEPTH];
   logic [UW-1:0]   exp_user [NQ][MODEL_DEPTH];
   logic            exp_last [NQ][MODEL_DEPTH];
   int              wr_idx [NQ];
   int              rd_idx [NQ];
   int              pkts_held [NQ];

   int            stim_seed;
   int            stall_seed;
   int            errors;
   int            words_checked;
   int            pkts_admitted;
   int            pkts_dropped;
   logic          freeze;
   logic          random_stall;
   logic [NQ-1:0] stall_mask;

   output_queues #(
      .DATA_WIDTH (DW),
      .USER_WIDTH (UW),
      .NUM_QUEUES (NQ)
   ) uut (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #5 axi_aclk = ~axi_aclk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Model helpers

   task automatic report_counts();
      $display("Words checked %0d, packets admitted %0d, dropped %0d, errors %0d, %s %0d",
               words_checked, pkts_admitted, pkts_dropped, errors,
               "assertion failures", uut.protocol_checks.fail_count);
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      report_counts();
      $display("Test FAILED");
      $finish;
   endtask

   function automatic int rand_len();
      return 1 + ($unsigned($random(stim_seed)) % 24);
   endfunction

   // Whole packet goes only if every selected queue has room
   function automatic logic predict_admit(input logic [NQ-1:0] dst);
      logic ok;
      int   q;
      ok = (dst != '0);
      for (q = 0; q < NQ; q++) begin
         if (dst[q] && ((wr_idx[q] - rd_idx[q] > ADMIT_LEVEL)
                        || (pkts_held[q] >= META_LIMIT))) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   task automatic push_word(input int q, input logic first);
      int slot;
      slot = wr_idx[q] % MODEL_DEPTH;
      exp_data[q][slot] = s_axis_tdata;
      exp_strb[q][slot] = s_axis_tstrb;
      exp_user[q][slot] = s_axis_tuser;
      exp_last[q][slot] = s_axis_tlast;
      wr_idx[q]++;
      if (first) begin
         pkts_held[q]++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus

   task automatic send_packet(input logic [NQ-1:0] dst, input int len);
      logic [UW-1:0] user;
      logic          admit;
      int            i;
      int            q;
      int            waited;
      // Quiet gap so admit_block matches the settled fill levels
      s_axis_tvalid = 1'b0;
      freeze        = 1'b1;
      repeat (2) @(negedge axi_aclk);
      user = {$random(stim_seed), $random(stim_seed), $random(stim_seed), $random(stim_seed)};
      for (q = 0; q < NQ; q++) begin
         user[DST_POS + 2 * q] = dst[q];
      end
      admit = predict_admit(dst);
      if (admit) begin
         pkts_admitted++;
      end else begin
         pkts_dropped++;
      end
      for (i = 0; i < len; i++) begin
         s_axis_tdata  = {$random(stim_seed), $random(stim_seed)};
         s_axis_tstrb  = (i == len - 1) ? (8'hff >> ($random(stim_seed) & 7)) : 8'hff;
         s_axis_tuser  = user;
         s_axis_tlast  = (i == len - 1);
         s_axis_tvalid = 1'b1;
         freeze        = 1'b0;
         waited        = 0;
         while (!s_axis_tready) begin
            @(negedge axi_aclk);
            waited++;
            if (waited > 8) begin
               abort_run("Timeout: input word was never accepted");
            end
         end
         // Word transfers at the coming rising edge
         for (q = 0; q < NQ; q++) begin
            if (admit && dst[q]) begin
               push_word(q, i == 0);
            end
         end
         @(negedge axi_aclk);
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic wait_drain();
      int   waited;
      int   q;
      logic busy;
      waited = 0;
      busy   = 1'b1;
      while (busy) begin
         busy = 1'b0;
         for (q = 0; q < NQ; q++) begin
            if (wr_idx[q] != rd_idx[q]) begin
               busy = 1'b1;
            end
         end
         if (busy) begin
            @(negedge axi_aclk);
            waited++;
            if (waited > 2000) begin
               abort_run("Timeout: queues did not drain, expected words are missing");
            end
         end
      end
      repeat (2) @(negedge axi_aclk);
      assert (m_axis_tvalid == '0) else begin
         errors++;
         $display("Mismatch at %0t: output still valid after the model drained", $time);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Output side driving tready and checking each transfer before its edge

   initial begin : output_monitor
      int   q;
      int   slot;
      logic ready;
      m_axis_tready = '0;
      forever begin
         @(negedge axi_aclk);
         for (q = 0; q < NQ; q++) begin
            ready = axi_resetn && !freeze && !stall_mask[q]
                    && !(random_stall && (($random(stall_seed) & 3) == 0));
            m_axis_tready[q] = ready;
            if (m_axis_tvalid[q] && ready) begin
               assert (wr_idx[q] != rd_idx[q]) else begin
                  errors++;
                  $display("Unexpected output word on queue %0d at %0t", q, $time);
               end
               if (wr_idx[q] != rd_idx[q]) begin
                  slot = rd_idx[q] % MODEL_DEPTH;
                  assert (m_axis_tdata[q*DW +: DW] == exp_data[q][slot]
                          && m_axis_tstrb[q*DW/8 +: DW/8] == exp_strb[q][slot]
                          && m_axis_tlast[q] == exp_last[q][slot]
                          && m_axis_tuser[q*UW +: UW] == exp_user[q][slot]) else begin
                     errors++;
                     $display("Mismatch at %0t: queue %0d got %h %b %h, expected %h %b %h",
                              $time, q, m_axis_tdata[q*DW +: DW], m_axis_tlast[q],
                              m_axis_tuser[q*UW +: UW], exp_data[q][slot],
                              exp_last[q][slot], exp_user[q][slot]);
                  end
                  if (exp_last[q][slot]) begin
                     pkts_held[q]--;
                  end
                  rd_idx[q]++;
                  words_checked++;
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int n;
      stim_seed     = SEED;
      stall_seed    = SEED;
      errors        = 0;
      words_checked = 0;
      pkts_admitted = 0;
      pkts_dropped  = 0;
      for (n = 0; n < NQ; n++) begin
         wr_idx[n]    = 0;
         rd_idx[n]    = 0;
         pkts_held[n] = 0;
      end
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      freeze        = 1'b0;
      random_stall  = 1'b0;
      stall_mask    = '0;
      repeat (3) @(negedge axi_aclk);
      axi_resetn = 1'b1;

      // Nothing comes out before the first packet
      repeat (4) begin
         @(negedge axi_aclk);
         assert (m_axis_tvalid == '0 && !s_axis_tready) else begin
            errors++;
            $display("Mismatch at %0t: valid or ready high after reset", $time);
         end
      end

      // Unicast to each queue and then multicast sets
      for (n = 0; n < 6; n++) begin
         send_packet(3'b001 << (n % NQ), rand_len());
      end
      send_packet(3'b101, rand_len());
      send_packet(3'b111, rand_len());
      send_packet(3'b011, rand_len());
      send_packet(3'b110, 1);

      // Queue 1 held off until admission blocks while the others keep flowing
      stall_mask = 3'b010;
      for (n = 0; n < 5; n++) begin
         send_packet(3'b010, rand_len());
      end
      send_packet(3'b011, rand_len());
      send_packet(3'b000, rand_len());
      send_packet(3'b001, rand_len());
      send_packet(3'b100, rand_len());
      stall_mask = '0;

      // Random destinations under random output stalls
      random_stall = 1'b1;
      for (n = 0; n < 40; n++) begin
         send_packet(NQ'($random(stim_seed)), rand_len());
      end
      wait_drain();

      report_counts();
      if (errors == 0 && uut.protocol_checks.fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
hw/oq_pkg.sv
hw/oq_stream_if.sv
hw/oq_fallthrough_fifo.sv
hw/oq_input_steer.sv
hw/oq_queue_port.sv
hw/output_queues.sv
tests/output_queues_assert.sv
tests/tb_output_queues.sv
